/* common/xc_cmd_pkg.sv */
package xc_cmd_pkg;

	// generic view, the low nibble selects the operation
	typedef struct packed {
		logic [3:0] arg;
		logic [3:0] opcode;
	} xc_cmd_base_t;

	// delay group view, opcodes 4 to 7 carry a 3 bit slice of a tap value
	typedef struct packed {
		logic       sel_lag;
		logic [2:0] value;
		logic [1:0] opgroup;
		logic [1:0] part;
	} xc_cmd_delay_t;

	typedef union packed {
		xc_cmd_base_t  base;
		xc_cmd_delay_t dly;
	} xc_cmd_t;

	// ********************
	// opcodes
	// ********************
	localparam logic [3:0] OP_CLEAR     = 4'd0;
	localparam logic [3:0] OP_SET_INDEX = 4'd1;
	localparam logic [3:0] OP_SET_FLAGS = 4'd2;
	localparam logic [3:0] OP_CAPTURE   = 4'd13;

	// matched against the opgroup field only
	localparam logic [1:0] OP_DELAY_GROUP = 2'b01;

endpackage

/* common/xc_data_pkg.sv */
`include "xc_params.svh"

package xc_data_pkg;

	// per lane conditioning flags and tap selection
	typedef struct packed {
		logic                                invert;
		logic                                edge_det;
		logic [$clog2(`XC_DELAY_DEPTH)-1:0] delay;
		logic [$clog2(`XC_DELAY_DEPTH)-1:0] lag;
	} xc_lane_cfg_t;

	// ascending ranges put lane 0 and pair 01 in the upper bits,
	// so they leave the serializer first
	typedef struct packed {
		logic [0:`XC_NUM_LANES-1][`XC_CNT_W-1:0] auto_cnt;
		logic [0:`XC_NUM_LANES-1][`XC_CNT_W-1:0] spec_cnt;
		logic [0:`XC_NUM_PAIRS-1][`XC_CNT_W-1:0] cross_cnt;
	} xc_counts_t;

endpackage

/* common/xc_params.svh */
`ifndef XC_PARAMS_SVH
`define XC_PARAMS_SVH

// ********************
// lane and counter sizing
// ********************

// number of photon input lanes
`define XC_NUM_LANES 4

// lane pairs for cross correlation, n*(n-1)/2
`define XC_NUM_PAIRS 6

// every auto, spectrum and cross counter has this width
`define XC_CNT_W 16

// taps per lane delay line, so tap selectors are 4 bits
`define XC_DELAY_DEPTH 16

// ********************
// packet framing
// ********************

`define XC_HDR_W 16

// header plus 14 counters of 16 bits each
`define XC_PKT_W 240
`define XC_PKT_NIBBLES 60

`endif

/* correlator/correlator_core.sv */
`include "xc_params.svh"

module correlator_core (
	input  logic                                           RXIF,
	input  logic                                           rst,
	input  logic [`XC_NUM_LANES-1:0]                       pulses,
	input  xc_data_pkg::xc_lane_cfg_t [`XC_NUM_LANES-1:0] lane_cfg,
	input  logic                                           capturing,
	input  logic                                           frame_req,
	output xc_data_pkg::xc_counts_t                        snapshot,
	output logic                                           snap_valid
);

	localparam int N = `XC_NUM_LANES;
	localparam int D = `XC_DELAY_DEPTH;
	localparam int CNT_W = `XC_CNT_W;

	// tap 0 is the conditioner output itself, so only taps 1 and up are stored
	logic [D-1:1][N-1:0] line;
	logic [N-1:0][D-1:0] lane_taps;
	logic [N-1:0]              auto_hit;
	logic [N-1:0]              spec_hit;
	logic [`XC_NUM_PAIRS-1:0]  cross_hit;
	xc_data_pkg::xc_counts_t   counts;

	function automatic logic [CNT_W-1:0] sat_inc(
		input logic [CNT_W-1:0] cnt,
		input logic             hit
	);
		logic [CNT_W-1:0] res;
		res = cnt;
		if (hit && (cnt != {CNT_W{1'b1}})) begin
			res = cnt + 1'b1;
		end
		return res;
	endfunction

	// ********************
	// delay lines and taps
	// ********************
	always_ff @(posedge RXIF) begin
		if (rst) begin
			line <= '0;
		end else begin
			line <= {line[D-2:1], pulses};
		end
	end

	always_comb begin
		for (int a = 0; a < N; a++) begin
			lane_taps[a][0] = pulses[a];
			for (int k = 1; k < D; k++) begin
				lane_taps[a][k] = line[k][a];
			end
			auto_hit[a] = lane_taps[a][lane_cfg[a].delay];
			// the decoder keeps delay plus lag within the line
			spec_hit[a] = auto_hit[a] & lane_taps[a][lane_cfg[a].delay + lane_cfg[a].lag];
		end
	end

	// pair order 01,02,03,12,13,23
	for (genvar a = 0; a < N; a++) begin : g_pair_a
		for (genvar b = a + 1; b < N; b++) begin : g_pair_b
			localparam int PI = a * (2 * N - a - 1) / 2 + b - a - 1;
			assign cross_hit[PI] = auto_hit[a] & auto_hit[b];
		end
	end

	// ********************
	// counters and snapshot
	// ********************
	always_ff @(posedge RXIF) begin
		if (rst) begin
			counts <= '0;
			snap_valid <= 1'b0;
		end else begin
			snap_valid <= frame_req;
			if (frame_req) begin
				counts <= '0;
			end else if (capturing) begin
				for (int a = 0; a < N; a++) begin
					counts.auto_cnt[a] <= sat_inc(counts.auto_cnt[a], auto_hit[a]);
					counts.spec_cnt[a] <= sat_inc(counts.spec_cnt[a], spec_hit[a]);
				end
				for (int p = 0; p < `XC_NUM_PAIRS; p++) begin
					counts.cross_cnt[p] <= sat_inc(counts.cross_cnt[p], cross_hit[p]);
				end
			end
		end
	end

	always_ff @(posedge RXIF) begin
		if (frame_req) begin
			snapshot <= counts;
		end
	end

	// frame requests arrive as single cycle strobes
	a_snap_pulse: assert property (@(posedge RXIF) disable iff (rst)
		snap_valid |=> !snap_valid);

endmodule

/* dv/xc_top_tb.sv */
`include "xc_params.svh"

module xc_top_tb;

	localparam int N = `XC_NUM_LANES;
	localparam logic [`XC_HDR_W-1:0] EXP_HDR = 16'h0310;

	typedef struct {
		string                       name;
		xc_cmd_pkg::xc_cmd_t [11:0]  cmds;
		int                          n_cmds;
		logic [3:0]                  pat;
		int                          run_len;
		bit                          rand_pat;
		bit                          zero_exp;
		xc_data_pkg::xc_counts_t     exp;
	} row_t;

	logic                    RXIF;
	logic                    rst;
	xc_cmd_pkg::xc_cmd_t     cmd;
	logic                    cmd_valid;
	logic [N-1:0]            lanes_in;
	logic                    frame_req;
	logic [3:0]              tx_nibble;
	logic                    tx_valid;
	logic                    tx_last;
	logic                    capturing;

	row_t   rows[6];
	integer seed = 17458;
	int     errors = 0;
	int     timeouts = 0;

	// reference model state, advanced once per rising edge
	xc_data_pkg::xc_lane_cfg_t m_cfg[N];
	logic [3:0]                m_dstage[N];
	logic [3:0]                m_lstage[N];
	logic [1:0]                m_idx;
	logic                      m_cap;
	logic                      m_lvl_q[N];
	logic                      m_pul[N];
	logic [15:1]               m_hist[N];
	xc_data_pkg::xc_counts_t   m_cnt;
	xc_data_pkg::xc_counts_t   m_snap;

	xc_top dut0 (
		.RXIF(RXIF), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .lanes_in(lanes_in),
		.frame_req(frame_req), .tx_nibble(tx_nibble), .tx_valid(tx_valid),
		.tx_last(tx_last), .capturing(capturing)
	);

	initial RXIF = 1'b0;
	always #50 RXIF = ~RXIF;

	// ********************
	// compare tasks
	// ********************
	task automatic check_counts(input string name, input xc_data_pkg::xc_counts_t exp,
			input xc_data_pkg::xc_counts_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_header(input string name, input logic [`XC_HDR_W-1:0] exp,
			input logic [`XC_HDR_W-1:0] act);
		if (act !== exp) begin
			$display("Fail %s header: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	// ********************
	// reference model
	// ********************
	function automatic logic [`XC_CNT_W-1:0] count_up(input logic [`XC_CNT_W-1:0] v,
			input logic hit);
		if (hit && (v != {`XC_CNT_W{1'b1}})) begin
			return v + 1'b1;
		end
		return v;
	endfunction

	function automatic logic [3:0] place_part(input logic [3:0] stage, input logic [1:0] part,
			input logic [2:0] value);
		logic [3:0] res;
		res = stage;
		if (part == 2'd0) begin
			res[2:0] = value;
		end else if (part == 2'd1) begin
			res[3] = value[0];
		end
		return res;
	endfunction

	task automatic model_reset();
		for (int a = 0; a < N; a++) begin
			m_cfg[a] = '0;
			m_dstage[a] = '0;
			m_lstage[a] = '0;
			m_lvl_q[a] = 1'b0;
			m_pul[a] = 1'b0;
			m_hist[a] = '0;
		end
		m_idx = '0;
		m_cap = 1'b0;
		m_cnt = '0;
		m_snap = '0;
	endtask

	task automatic model_cmd(input xc_cmd_pkg::xc_cmd_t c);
		int s;
		if (c.dly.opgroup == xc_cmd_pkg::OP_DELAY_GROUP) begin
			if (c.dly.sel_lag) begin
				m_lstage[m_idx] = place_part(m_lstage[m_idx], c.dly.part, c.dly.value);
			end else begin
				m_dstage[m_idx] = place_part(m_dstage[m_idx], c.dly.part, c.dly.value);
			end
			s = int'(m_dstage[m_idx]) + int'(m_lstage[m_idx]);
			m_cfg[m_idx].delay = m_dstage[m_idx];
			// an oversized lag is cut back to reach tap 15 exactly
			m_cfg[m_idx].lag = (s > 15) ? 4'(15 - int'(m_dstage[m_idx])) : m_lstage[m_idx];
		end else if (c.base.opcode == xc_cmd_pkg::OP_CLEAR) begin
			m_dstage[m_idx] = '0;
			m_lstage[m_idx] = '0;
			m_cfg[m_idx].delay = '0;
			m_cfg[m_idx].lag = '0;
		end else if (c.base.opcode == xc_cmd_pkg::OP_SET_INDEX) begin
			m_idx = c.base.arg[1:0];
		end else if (c.base.opcode == xc_cmd_pkg::OP_SET_FLAGS) begin
			m_cfg[m_idx].invert = c.base.arg[0];
			m_cfg[m_idx].edge_det = c.base.arg[1];
		end else if (c.base.opcode == xc_cmd_pkg::OP_CAPTURE) begin
			m_cap = c.base.arg[0];
		end
	endtask

	// counters read the old taps, so the blocks are updated back to front
	task automatic model_step(input xc_cmd_pkg::xc_cmd_t c, input logic v,
			input logic [N-1:0] l, input logic f);
		logic [15:0] taps;
		logic [3:0]  spec_tap;
		logic        auto_h[N];
		logic        lvl;
		int          p;
		if (f) begin
			m_snap = m_cnt;
			m_cnt = '0;
		end else if (m_cap) begin
			for (int a = 0; a < N; a++) begin
				taps = {m_hist[a], m_pul[a]};
				spec_tap = m_cfg[a].delay + m_cfg[a].lag;
				auto_h[a] = taps[m_cfg[a].delay];
				m_cnt.auto_cnt[2'(a)] = count_up(m_cnt.auto_cnt[2'(a)], auto_h[a]);
				m_cnt.spec_cnt[2'(a)] = count_up(m_cnt.spec_cnt[2'(a)],
					auto_h[a] & taps[spec_tap]);
			end
			p = 0;
			for (int a = 0; a < N; a++) begin
				for (int b = a + 1; b < N; b++) begin
					m_cnt.cross_cnt[3'(p)] = count_up(m_cnt.cross_cnt[3'(p)],
						auto_h[a] & auto_h[b]);
					p++;
				end
			end
		end
		for (int a = 0; a < N; a++) begin
			m_hist[a] = {m_hist[a][14:1], m_pul[a]};
			lvl = l[2'(a)] ^ m_cfg[a].invert;
			m_pul[a] = m_cfg[a].edge_det ? (lvl & ~m_lvl_q[a]) : lvl;
			m_lvl_q[a] = lvl;
		end
		if (v) begin
			model_cmd(c);
		end
	endtask

	// ********************
	// stimulus
	// ********************
	task automatic drive_cycle(input xc_cmd_pkg::xc_cmd_t c, input logic v,
			input logic [N-1:0] l, input logic f);
		@(negedge RXIF);
		cmd = c;
		cmd_valid = v;
		lanes_in = l;
		frame_req = f;
		model_step(c, v, l, f);
	endtask

	function automatic xc_cmd_pkg::xc_cmd_t op_cmd(input logic [3:0] op, input logic [3:0] arg);
		xc_cmd_pkg::xc_cmd_t c;
		c.base.opcode = op;
		c.base.arg = arg;
		return c;
	endfunction

	function automatic xc_cmd_pkg::xc_cmd_t tap_cmd(input logic sel_lag, input logic [1:0] part,
			input logic [2:0] value);
		xc_cmd_pkg::xc_cmd_t c;
		c.dly.sel_lag = sel_lag;
		c.dly.value = value;
		c.dly.opgroup = xc_cmd_pkg::OP_DELAY_GROUP;
		c.dly.part = part;
		return c;
	endfunction

	task automatic add_cmd(input int r, input xc_cmd_pkg::xc_cmd_t c);
		rows[r].cmds[4'(rows[r].n_cmds)] = c;
		rows[r].n_cmds++;
	endtask

	task automatic add_row(input int r, input string name, input logic [3:0] pat,
			input int run_len, input bit rand_pat, input bit zero_exp);
		rows[r].name = name;
		rows[r].cmds = '0;
		rows[r].n_cmds = 0;
		rows[r].pat = pat;
		rows[r].run_len = run_len;
		rows[r].rand_pat = rand_pat;
		rows[r].zero_exp = zero_exp;
		rows[r].exp = '0;
	endtask

	task automatic build_table();
		add_row(0, "capture_off", 4'b1010, 30, 1'b0, 1'b1);
		add_cmd(0, op_cmd(xc_cmd_pkg::OP_CAPTURE, 4'd0));
		add_row(1, "zero_delay", 4'b0110, 40, 1'b0, 1'b0);
		add_cmd(1, op_cmd(xc_cmd_pkg::OP_CAPTURE, 4'd1));
		// lane 2 asks for delay 12 and lag 7, which the decoder cuts to lag 3
		add_row(2, "delay_lag", 4'b1001, 60, 1'b0, 1'b0);
		add_cmd(2, op_cmd(xc_cmd_pkg::OP_SET_INDEX, 4'd0));
		add_cmd(2, tap_cmd(1'b1, 2'd1, 3'd1));
		add_cmd(2, tap_cmd(1'b0, 2'd0, 3'd3));
		add_cmd(2, op_cmd(xc_cmd_pkg::OP_SET_INDEX, 4'd1));
		add_cmd(2, tap_cmd(1'b0, 2'd0, 3'd5));
		add_cmd(2, op_cmd(xc_cmd_pkg::OP_SET_INDEX, 4'd2));
		add_cmd(2, tap_cmd(1'b0, 2'd0, 3'd4));
		add_cmd(2, tap_cmd(1'b0, 2'd1, 3'd1));
		add_cmd(2, tap_cmd(1'b1, 2'd0, 3'd7));
		add_cmd(2, op_cmd(xc_cmd_pkg::OP_SET_INDEX, 4'd3));
		add_cmd(2, tap_cmd(1'b1, 2'd0, 3'd2));
		add_row(3, "invert_edge", 4'b0101, 50, 1'b0, 1'b0);
		add_cmd(3, op_cmd(xc_cmd_pkg::OP_SET_INDEX, 4'd0));
		add_cmd(3, op_cmd(xc_cmd_pkg::OP_SET_FLAGS, 4'd1));
		add_cmd(3, op_cmd(xc_cmd_pkg::OP_SET_INDEX, 4'd1));
		add_cmd(3, op_cmd(xc_cmd_pkg::OP_SET_FLAGS, 4'd3));
		add_cmd(3, op_cmd(xc_cmd_pkg::OP_SET_INDEX, 4'd3));
		add_cmd(3, op_cmd(xc_cmd_pkg::OP_SET_FLAGS, 4'd2));
		add_cmd(3, op_cmd(xc_cmd_pkg::OP_SET_INDEX, 4'd2));
		add_cmd(3, op_cmd(xc_cmd_pkg::OP_CLEAR, 4'd0));
		add_row(4, "random_200", 4'b0000, 200, 1'b1, 1'b0);
		add_cmd(4, op_cmd(xc_cmd_pkg::OP_SET_INDEX, 4'd0));
		add_cmd(4, op_cmd(xc_cmd_pkg::OP_SET_FLAGS, 4'd0));
		add_cmd(4, op_cmd(xc_cmd_pkg::OP_SET_INDEX, 4'd1));
		add_cmd(4, op_cmd(xc_cmd_pkg::OP_SET_FLAGS, 4'd0));
		add_cmd(4, op_cmd(xc_cmd_pkg::OP_SET_INDEX, 4'd3));
		add_cmd(4, op_cmd(xc_cmd_pkg::OP_SET_FLAGS, 4'd0));
		// the frame before this one already emptied every counter
		add_row(5, "counters_cleared", 4'b0000, 0, 1'b0, 1'b1);
	endtask

	task automatic run_row(input int r);
		logic [`XC_PKT_W-1:0]    pkt;
		logic [3:0]              pv;
		xc_data_pkg::xc_counts_t act;
		int                      wait_n;
		int                      n;
		int                      n_last;
		int                      last_at;
		for (int j = 0; j < rows[r].n_cmds; j++) begin
			drive_cycle(rows[r].cmds[4'(j)], 1'b1, '0, 1'b0);
		end
		for (int t = 0; t < rows[r].run_len; t++) begin
			pv = rows[r].rand_pat ? 4'($random(seed)) : (rows[r].pat ^ 4'(t));
			drive_cycle('0, 1'b0, pv, 1'b0);
		end
		repeat (20) drive_cycle('0, 1'b0, '0, 1'b0);
		check_flag({rows[r].name, " capturing"}, m_cap, capturing);
		drive_cycle('0, 1'b0, '0, 1'b1);
		if (!rows[r].zero_exp) begin
			rows[r].exp = m_snap;
		end
		wait_n = 0;
		do begin
			drive_cycle('0, 1'b0, '0, 1'b0);
			wait_n++;
		end while (!tx_valid && wait_n < 200);
		if (!tx_valid) begin
			$display("no packet within 200 cycles in test %s", rows[r].name);
			timeouts++;
		end else begin
			check_count({rows[r].name, " latency"}, 2, wait_n);
			pkt = '0;
			n = 0;
			n_last = 0;
			last_at = -1;
			while (tx_valid && n < 100) begin
				pkt = {pkt[`XC_PKT_W-5:0], tx_nibble};
				if (tx_last) begin
					n_last++;
					last_at = n;
				end
				n++;
				drive_cycle('0, 1'b0, '0, 1'b0);
			end
			if (tx_valid) begin
				$display("packet in test %s did not end within 100 nibbles", rows[r].name);
				timeouts++;
			end
			act = xc_data_pkg::xc_counts_t'(pkt[`XC_PKT_W-`XC_HDR_W-1:0]);
			check_count({rows[r].name, " nibbles"}, `XC_PKT_NIBBLES, n);
			check_count({rows[r].name, " tx_last count"}, 1, n_last);
			check_count({rows[r].name, " tx_last position"}, `XC_PKT_NIBBLES - 1, last_at);
			check_header(rows[r].name, EXP_HDR, pkt[`XC_PKT_W-1 -: `XC_HDR_W]);
			check_counts(rows[r].name, rows[r].exp, act);
		end
	endtask

	initial begin
		rst = 1'b1;
		cmd = '0;
		cmd_valid = 1'b0;
		lanes_in = '0;
		frame_req = 1'b0;
		model_reset();
		build_table();
		repeat (4) @(posedge RXIF);
		@(negedge RXIF);
		rst = 1'b0;
		for (int r = 0; r < 6; r++) begin
			run_row(r);
		end
		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* hdl/packet_serializer.sv */
`include "xc_params.svh"

module packet_serializer (
	input  logic                    RXIF,
	input  logic                    rst,
	input  xc_data_pkg::xc_counts_t snapshot,
	input  logic                    snap_valid,
	output logic [3:0]              tx_nibble,
	output logic                    tx_valid,
	output logic                    tx_last
);

	localparam int NIB_W = $clog2(`XC_PKT_NIBBLES);
	localparam logic [NIB_W-1:0] LAST_NIB = NIB_W'(`XC_PKT_NIBBLES - 1);

	// lane count minus one over counter width
	localparam logic [`XC_HDR_W-1:0] HEADER = {8'(`XC_NUM_LANES - 1), 8'(`XC_CNT_W)};

	logic [`XC_PKT_W-1:0] shift_q;
	logic [NIB_W-1:0]     nib_cnt;
	logic                 load;

	// a snapshot that shows up mid packet is dropped here
	assign load = snap_valid && !tx_valid;
	assign tx_nibble = shift_q[`XC_PKT_W-1 -: 4];

	always_ff @(posedge RXIF) begin
		if (rst) begin
			tx_valid <= 1'b0;
			tx_last <= 1'b0;
			nib_cnt <= '0;
		end else if (load) begin
			tx_valid <= 1'b1;
			tx_last <= 1'b0;
			nib_cnt <= '0;
		end else if (tx_valid) begin
			nib_cnt <= nib_cnt + 1'b1;
			tx_last <= (nib_cnt == LAST_NIB - 1'b1);
			if (nib_cnt == LAST_NIB) begin
				tx_valid <= 1'b0;
			end
		end
	end

	// ********************
	// payload shift register
	// ********************
	always_ff @(posedge RXIF) begin
		if (load) begin
			shift_q <= {HEADER, snapshot};
		end else if (tx_valid) begin
			shift_q <= {shift_q[`XC_PKT_W-5:0], 4'h0};
		end
	end

	a_last_in_packet: assert property (@(posedge RXIF) disable iff (rst)
		tx_last |-> tx_valid);

endmodule

/* hdl/pulse_conditioner.sv */
`include "xc_params.svh"

module pulse_conditioner (
	input  logic                                           RXIF,
	input  logic                                           rst,
	input  logic [`XC_NUM_LANES-1:0]                       lanes_in,
	input  xc_data_pkg::xc_lane_cfg_t [`XC_NUM_LANES-1:0] lane_cfg,
	output logic [`XC_NUM_LANES-1:0]                       pulses
);

	logic [`XC_NUM_LANES-1:0] level;
	logic [`XC_NUM_LANES-1:0] level_q;
	logic [`XC_NUM_LANES-1:0] edge_sel;

	always_comb begin
		for (int i = 0; i < `XC_NUM_LANES; i++) begin
			level[i] = lanes_in[i] ^ lane_cfg[i].invert;
			edge_sel[i] = lane_cfg[i].edge_det;
		end
	end

	// level_q tracks the inverted input even while edge mode is off,
	// so switching modes gives no stale edge
	always_ff @(posedge RXIF) begin
		if (rst) begin
			level_q <= '0;
			pulses <= '0;
		end else begin
			level_q <= level;
			pulses <= (edge_sel & level & ~level_q) | (~edge_sel & level);
		end
	end

endmodule

/* hdl/xc_cmd_decoder.sv */
`include "xc_params.svh"

module xc_cmd_decoder (
	input  logic                                           RXIF,
	input  logic                                           rst,
	input  xc_cmd_pkg::xc_cmd_t                            cmd,
	input  logic                                           cmd_valid,
	output xc_data_pkg::xc_lane_cfg_t [`XC_NUM_LANES-1:0] lane_cfg,
	output logic                                           capturing
);

	localparam int IDX_W = $clog2(`XC_NUM_LANES);
	localparam int TAP_W = $clog2(`XC_DELAY_DEPTH);
	localparam logic [TAP_W:0] TAP_MAX = (TAP_W+1)'(`XC_DELAY_DEPTH - 1);

	logic [IDX_W-1:0]                     lane_idx;
	logic [`XC_NUM_LANES-1:0][TAP_W-1:0] delay_stage;
	logic [`XC_NUM_LANES-1:0][TAP_W-1:0] lag_stage;

	logic             is_delay_cmd;
	logic [TAP_W-1:0] delay_next;
	logic [TAP_W-1:0] lag_next;
	logic [TAP_W-1:0] lag_clamped;
	logic [TAP_W:0]   tap_sum;

	// part 0 fills bits 2:0, part 1 fills bit 3 from value bit 0
	function automatic logic [TAP_W-1:0] merge_part(
		input logic [TAP_W-1:0] stage,
		input logic [1:0]       part,
		input logic [2:0]       value
	);
		logic [TAP_W-1:0] res;
		res = stage;
		case (part)
			2'd0: res[2:0] = value;
			2'd1: res[3] = value[0];
			default: res = stage;
		endcase
		return res;
	endfunction

	// ********************
	// staging update and clamp
	// ********************
	always_comb begin
		is_delay_cmd = (cmd.dly.opgroup == xc_cmd_pkg::OP_DELAY_GROUP);
		delay_next = delay_stage[lane_idx];
		lag_next = lag_stage[lane_idx];
		if (is_delay_cmd) begin
			if (cmd.dly.sel_lag) begin
				lag_next = merge_part(lag_stage[lane_idx], cmd.dly.part, cmd.dly.value);
			end else begin
				delay_next = merge_part(delay_stage[lane_idx], cmd.dly.part, cmd.dly.value);
			end
		end
		// the lag gives way so the spectrum tap stays inside the delay line
		tap_sum = {1'b0, delay_next} + {1'b0, lag_next};
		lag_clamped = (tap_sum > TAP_MAX) ? TAP_W'(TAP_MAX - {1'b0, delay_next}) : lag_next;
	end

	always_ff @(posedge RXIF) begin
		if (rst) begin
			lane_idx <= '0;
			delay_stage <= '0;
			lag_stage <= '0;
			lane_cfg <= '0;
			capturing <= 1'b0;
		end else if (cmd_valid) begin
			if (is_delay_cmd) begin
				delay_stage[lane_idx] <= delay_next;
				lag_stage[lane_idx] <= lag_next;
				lane_cfg[lane_idx].delay <= delay_next;
				lane_cfg[lane_idx].lag <= lag_clamped;
			end else begin
				case (cmd.base.opcode)
					xc_cmd_pkg::OP_CLEAR: begin
						delay_stage[lane_idx] <= '0;
						lag_stage[lane_idx] <= '0;
						lane_cfg[lane_idx].delay <= '0;
						lane_cfg[lane_idx].lag <= '0;
					end
					xc_cmd_pkg::OP_SET_INDEX: lane_idx <= cmd.base.arg[IDX_W-1:0];
					xc_cmd_pkg::OP_SET_FLAGS: begin
						lane_cfg[lane_idx].invert <= cmd.base.arg[0];
						lane_cfg[lane_idx].edge_det <= cmd.base.arg[1];
					end
					xc_cmd_pkg::OP_CAPTURE: capturing <= cmd.base.arg[0];
					default: ;
				endcase
			end
		end
	end

	// the correlator indexes delay plus lag without a range check
	for (genvar i = 0; i < `XC_NUM_LANES; i++) begin : g_tap_chk
		a_tap_range: assert property (@(posedge RXIF) disable iff (rst)
			({1'b0, lane_cfg[i].delay} + {1'b0, lane_cfg[i].lag}) <= TAP_MAX);
	end

endmodule

/* hdl/xc_top.sv */
`include "xc_params.svh"

module xc_top (
	input  logic                     RXIF,
	input  logic                     rst,
	input  xc_cmd_pkg::xc_cmd_t      cmd,
	input  logic                     cmd_valid,
	input  logic [`XC_NUM_LANES-1:0] lanes_in,
	input  logic                     frame_req,
	output logic [3:0]               tx_nibble,
	output logic                     tx_valid,
	output logic                     tx_last,
	output logic                     capturing
);

	xc_data_pkg::xc_lane_cfg_t [`XC_NUM_LANES-1:0] lane_cfg;
	logic [`XC_NUM_LANES-1:0]                       pulses;
	xc_data_pkg::xc_counts_t                        snapshot;
	logic                                           snap_valid;

	// input side
	xc_cmd_decoder u_decoder (
		.RXIF(RXIF), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid),
		.lane_cfg(lane_cfg), .capturing(capturing)
	);

	pulse_conditioner u_conditioner (
		.RXIF(RXIF), .rst(rst), .lanes_in(lanes_in), .lane_cfg(lane_cfg), .pulses(pulses)
	);

	correlator_core u_core (
		.RXIF(RXIF), .rst(rst), .pulses(pulses), .lane_cfg(lane_cfg),
		.capturing(capturing), .frame_req(frame_req),
		.snapshot(snapshot), .snap_valid(snap_valid)
	);

	// output side
	packet_serializer u_serializer (
		.RXIF(RXIF), .rst(rst), .snapshot(snapshot), .snap_valid(snap_valid),
		.tx_nibble(tx_nibble), .tx_valid(tx_valid), .tx_last(tx_last)
	);

endmodule

/* run.sh */
#!/bin/sh
# build and run the xc_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module xc_top_tb -f xc_top.f

out=$(./obj_dir/Vxc_top_tb)
echo "$out"

if echo "$out" | grep -q "Verification passed"; then
	exit 0
else
	exit 1
fi

/* xc_top.f */
+incdir+common
common/xc_cmd_pkg.sv
common/xc_data_pkg.sv
hdl/xc_cmd_decoder.sv
hdl/pulse_conditioner.sv
correlator/correlator_core.sv
hdl/packet_serializer.sv
hdl/xc_top.sv
dv/xc_top_tb.sv
